//--- src.f
hw/chdr_pkg.sv
hw/xbar_pkg.sv
hw/xb_route_table.sv
hw/xb_ingress_router.sv
hw/xb_stream_fifo.sv
hw/xb_egress_arbiter.sv
hw/chdr_crossbar.sv
sim/chdr_crossbar_sva.sv
sim/tb_chdr_crossbar.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_chdr_crossbar
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Print everything and succeed only if the pass line shows up
run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | \
		awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_chdr_crossbar.sv
`timescale 1ns/10ps

module tb_chdr_crossbar import chdr_pkg::*, xbar_pkg::*; ();

  localparam logic [31:0] LFSR_SEED = 32'h2afe8513;
  localparam logic [31:0] LFSR_POLY = 32'h80200003;

  // Beats per test, the back-pressure count is its worst case
  localparam int MAPPED_BEATS  = 14;
  localparam int DEFAULT_BEATS = 3;
  localparam int REMAP_BEATS   = 16;
  localparam int REPLACE_BEATS = 6;
  localparam int CONTEND_BEATS = 18;
  localparam int BP_BEATS      = 64;
  localparam int TOTAL_BEATS   = MAPPED_BEATS + DEFAULT_BEATS + REMAP_BEATS +
                                 REPLACE_BEATS + CONTEND_BEATS + BP_BEATS;
  // Config writes and resets are covered by the fixed margin
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * int'(NPORTS) * 20 + 400;

  logic              clk = 1'b0;
  logic              reset = 1'b1;
  chdr_beat_t        in_beat [NPORTS] = '{default: '0};
  logic [NPORTS-1:0] in_valid = '0;
  logic [NPORTS-1:0] in_ready;
  chdr_beat_t        out_beat [NPORTS];
  logic [NPORTS-1:0] out_valid;
  logic [NPORTS-1:0] out_ready = '1;
  logic              cfg_stb = 1'b0;
  route_cfg_t        cfg = '0;
  logic              cfg_ack;

  // Beats waiting to be offered on each input, head is the one on the bus
  chdr_beat_t send_q [NPORTS][$];
  // Expected beats, indexed by output * NPORTS + input
  chdr_beat_t exp_q [NPORTS*NPORTS][$];
  // Beats seen on each output and the source input of every packet head
  chdr_beat_t rx_q [NPORTS][$];
  port_t      head_log [NPORTS][$];
  // Reference routing table, oldest entry at the front
  route_cfg_t model_tbl [$];

  logic [31:0] lfsr = LFSR_SEED;
  logic        bp_en = 1'b0;
  int          expected_beats = 0;
  int          rx_count = 0;
  int          errors = 0;
  int          tests_run = 0;

  chdr_crossbar uut (
    .clk         (clk),
    .reset       (reset),
    .i_in_beat   (in_beat),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out_beat  (out_beat),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .i_cfg_stb   (cfg_stb),
    .i_cfg       (cfg),
    .o_cfg_ack   (cfg_ack)
  );

  bind chdr_crossbar chdr_crossbar_sva sva_i (
    .clk         (clk),
    .reset       (reset),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_cfg_stb   (i_cfg_stb),
    .o_cfg_ack   (o_cfg_ack)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // Random bits, stimulus drivers and output monitor
  // --------------------------------------------------------------------------

  // Galois LFSR, one step for every bit handed out
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        b;
    v = '0;
    for (int k = 0; k < n; k++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ LFSR_POLY;
      end
      v = {v[62:0], b};
    end
    return v;
  endfunction

  // Retire accepted beats at the edge, present the next ones 1 ns later
  always @(posedge clk) begin
    for (int p = 0; p < NPORTS; p++) begin
      if (in_valid[p] && in_ready[p]) begin
        void'(send_q[p].pop_front());
      end
    end
    #1;
    for (int p = 0; p < NPORTS; p++) begin
      if (send_q[p].size() > 0) begin
        in_beat[p]  = send_q[p][0];
        in_valid[p] = 1'b1;
      end else begin
        in_valid[p] = 1'b0;
      end
    end
    out_ready = bp_en ? NPORTS'(take_bits(NPORTS)) : '1;
  end

  always @(posedge clk) begin
    if (!reset) begin
      for (int o = 0; o < NPORTS; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          rx_q[o].push_back(out_beat[o]);
          rx_count++;
        end
      end
    end
  end

  // Hard stop if traffic never drains
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------

  task automatic check_beat(input string name, input chdr_beat_t act, input chdr_beat_t exp);
    if (act !== exp) begin
      $display("ERR %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_port(input string name, input port_t act, input port_t exp);
    if (act !== exp) begin
      $display("ERR %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_ack(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERR %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference table and stimulus helpers
  // --------------------------------------------------------------------------

  // Known IDs change in place, new IDs push out the oldest entry when full
  task automatic model_write(input route_cfg_t c);
    logic found;
    found = 1'b0;
    foreach (model_tbl[k]) begin
      if (model_tbl[k].epid == c.epid) begin
        model_tbl[k] = c;
        found        = 1'b1;
      end
    end
    if (!found) begin
      if (model_tbl.size() == TBL_SIZE) begin
        void'(model_tbl.pop_front());
      end
      model_tbl.push_back(c);
    end
  endtask

  function automatic port_t expected_port(input epid_t id);
    port_t p;
    p = DEFAULT_PORT;
    foreach (model_tbl[k]) begin
      if (model_tbl[k].epid == id) begin
        p = model_tbl[k].port;
      end
    end
    return p;
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    model_tbl.delete();
  endtask

  // Strobe for one cycle, the ack is high in the following cycle only
  task automatic write_route(input epid_t id, input port_t port);
    route_cfg_t c;
    c.epid  = id;
    c.port  = port;
    cfg     = c;
    cfg_stb = 1'b1;
    @(posedge clk);
    #1;
    check_ack("o_cfg_ack", cfg_ack, 1'b1);
    cfg_stb = 1'b0;
    @(posedge clk);
    #1;
    check_ack("o_cfg_ack", cfg_ack, 1'b0);
    model_write(c);
  endtask

  // The header carries the ID, the source input and the expected output,
  // the rest of every word is random
  task automatic send_packet(input port_t src, input epid_t id, input int len);
    port_t      dst;
    chdr_beat_t b;
    dst = expected_port(id);
    for (int k = 0; k < len; k++) begin
      b.last = (k == len - 1);
      b.data = take_bits(64);
      if (k == 0) begin
        b.data[EPID_W-1:0]             = id;
        b.data[EPID_W +: PORT_W]        = src;
        b.data[EPID_W+PORT_W +: PORT_W] = dst;
      end
      send_q[src].push_back(b);
      exp_q[int'(dst) * NPORTS + int'(src)].push_back(b);
      expected_beats++;
    end
  endtask

  task automatic wait_drained();
    while (rx_count < expected_beats) @(negedge clk);
    bp_en = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // Rebuild packets per output and match them against the expected beats
  task automatic check_rx();
    chdr_beat_t b;
    chdr_beat_t e;
    port_t      src;
    port_t      dst;
    logic       in_pkt;
    int         q;
    src = '0;
    dst = '0;
    for (int o = 0; o < NPORTS; o++) begin
      in_pkt = 1'b0;
      while (rx_q[o].size() > 0) begin
        b = rx_q[o].pop_front();
        if (!in_pkt) begin
          src = b.data[EPID_W +: PORT_W];
          dst = b.data[EPID_W+PORT_W +: PORT_W];
          check_port("o_out_valid index", port_t'(o), dst);
          head_log[o].push_back(src);
        end
        q = int'(dst) * NPORTS + int'(src);
        if (exp_q[q].size() == 0) begin
          $display("unexpected beat on output %0d from input %0d", o, src);
          errors++;
        end else begin
          e = exp_q[q].pop_front();
          check_beat("o_out_beat", b, e);
        end
        in_pkt = !b.last;
      end
    end
    for (int k = 0; k < NPORTS * NPORTS; k++) begin
      if (exp_q[k].size() != 0) begin
        $display("%0d beats from input %0d never reached output %0d",
                 exp_q[k].size(), k % NPORTS, k / NPORTS);
        errors++;
        exp_q[k].delete();
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  task automatic test_mapped_routing();
    int e0;
    e0 = errors;
    for (int i = 0; i < NPORTS; i++) begin
      write_route(16'h0010 + epid_t'(i), port_t'(3 - i));
    end
    @(negedge clk);
    for (int i = 0; i < NPORTS; i++) begin
      send_packet(port_t'(i), 16'h0010 + epid_t'(i), 2 + i);
    end
    wait_drained();
    check_rx();
    finish_test("mapped routing", e0);
  endtask

  task automatic test_default_port();
    int e0;
    e0 = errors;
    @(negedge clk);
    send_packet(port_t'(1), 16'h0099, 3);
    wait_drained();
    check_rx();
    finish_test("default port", e0);
  endtask

  // Fill the table to eight entries, then move 0x10 without evicting anyone
  task automatic test_remap_in_place();
    int e0;
    e0 = errors;
    for (int i = 0; i < NPORTS; i++) begin
      write_route(16'h0014 + epid_t'(i), port_t'((i * 3 + 1) % 4));
    end
    write_route(16'h0010, port_t'(1));
    @(negedge clk);
    for (int k = 0; k < TBL_SIZE; k++) begin
      send_packet(port_t'(k % 4), 16'h0010 + epid_t'(k), 2);
    end
    wait_drained();
    check_rx();
    finish_test("remap in place", e0);
  endtask

  // Nine IDs into an empty table, the ninth evicts the first
  task automatic test_oldest_replacement();
    int e0;
    e0 = errors;
    apply_reset();
    for (int k = 0; k < 9; k++) begin
      write_route(16'h0020 + epid_t'(k), port_t'(k % 3 + 1));
    end
    @(negedge clk);
    send_packet(port_t'(1), 16'h0020, 2);
    send_packet(port_t'(2), 16'h0028, 2);
    send_packet(port_t'(3), 16'h0021, 2);
    wait_drained();
    check_rx();
    finish_test("oldest-first replacement", e0);
  endtask

  // Fresh reset puts the round-robin pointer back so input 0 wins first
  task automatic test_contention();
    int e0;
    e0 = errors;
    apply_reset();
    write_route(16'h0030, port_t'(1));
    for (int o = 0; o < NPORTS; o++) begin
      head_log[o].delete();
    end
    @(negedge clk);
    for (int k = 0; k < 3; k++) begin
      send_packet(port_t'(0), 16'h0030, 3);
      send_packet(port_t'(2), 16'h0030, 3);
    end
    wait_drained();
    check_rx();
    if (head_log[1].size() != 6) begin
      $display("output 1 saw %0d packets instead of 6", head_log[1].size());
      errors++;
    end else begin
      for (int k = 0; k < 6; k++) begin
        check_port("grant order", head_log[1][k], port_t'((k % 2) * 2));
      end
    end
    finish_test("contention and fairness", e0);
  endtask

  task automatic test_backpressure();
    int    e0;
    epid_t id;
    int    len;
    e0 = errors;
    for (int i = 0; i < NPORTS; i++) begin
      write_route(16'h0040 + epid_t'(i), port_t'((i + 2) % 4));
    end
    @(negedge clk);
    for (int i = 0; i < NPORTS; i++) begin
      for (int k = 0; k < 4; k++) begin
        id  = 16'h0040 + epid_t'(take_bits(2));
        len = 1 + int'(take_bits(2));
        send_packet(port_t'(i), id, len);
      end
    end
    bp_en = 1'b1;
    wait_drained();
    check_rx();
    finish_test("back-pressure", e0);
  endtask

  initial begin
    int sva_fails;
    apply_reset();
    test_mapped_routing();
    test_default_port();
    test_remap_in_place();
    test_oldest_replacement();
    test_contention();
    test_backpressure();
    sva_fails = uut.sva_i.fail_count;
    errors    = errors + sva_fails;
    $display("summary: %0d tests run, %0d errors, %0d of them from assertions",
             tests_run, errors, sva_fails);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim/chdr_crossbar_sva.sv
`timescale 1ns/10ps

module chdr_crossbar_sva import chdr_pkg::*, xbar_pkg::*; (
  input logic              clk,
  input logic              reset,
  input chdr_beat_t        o_out_beat [NPORTS],
  input logic [NPORTS-1:0] o_out_valid,
  input logic [NPORTS-1:0] i_out_ready,
  input logic              i_cfg_stb,
  input logic              o_cfg_ack
);

  // Failure tallies, one per assertion site so that each has a single writer
  int n_ack_late  = 0;
  int n_ack_extra = 0;
  int n_reset     = 0;
  int n_stall [NPORTS] = '{default: 0};

  // Total read back by the testbench at the end of the run
  int fail_count;

  always_comb begin
    fail_count = n_ack_late + n_ack_extra + n_reset;
    for (int n = 0; n < NPORTS; n++) begin
      fail_count = fail_count + n_stall[n];
    end
  end

  // --------------------------------------------------------------------------
  // Config port
  // --------------------------------------------------------------------------

  // Every strobe is answered exactly one cycle later
  a_ack_late: assert property (@(posedge clk) disable iff (reset)
    i_cfg_stb |=> o_cfg_ack)
    else begin
      $error("config ack missing one cycle after strobe");
      n_ack_late++;
    end

  // And an ack never shows up without a strobe the cycle before
  a_ack_extra: assert property (@(posedge clk) disable iff (reset)
    o_cfg_ack |-> $past(i_cfg_stb))
    else begin
      $error("config ack without a preceding strobe");
      n_ack_extra++;
    end

  // Outputs are idle from the first reset edge on
  a_idle_in_reset: assert property (@(posedge clk)
    reset |=> ((o_out_valid == '0) && !o_cfg_ack))
    else begin
      $error("valid or ack high while reset is held");
      n_reset++;
    end

  // --------------------------------------------------------------------------
  // Output streams
  // --------------------------------------------------------------------------

  for (genvar n = 0; n < NPORTS; n++) begin : g_out
    // A stalled beat stays offered and does not change
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
      (o_out_valid[n] && !i_out_ready[n]) |=> (o_out_valid[n] && $stable(o_out_beat[n])))
      else begin
        $error("output %0d dropped or changed a stalled beat", n);
        n_stall[n]++;
      end
  end

endmodule

//--- hw/chdr_crossbar.sv
`timescale 1ns/10ps

module chdr_crossbar import chdr_pkg::*, xbar_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  // Input ports
  input  chdr_beat_t        i_in_beat [NPORTS],
  input  logic [NPORTS-1:0] i_in_valid,
  output logic [NPORTS-1:0] o_in_ready,
  // Output ports
  output chdr_beat_t        o_out_beat [NPORTS],
  output logic [NPORTS-1:0] o_out_valid,
  input  logic [NPORTS-1:0] i_out_ready,
  // Routing table config
  input  logic              i_cfg_stb,
  input  route_cfg_t        i_cfg,
  output logic              o_cfg_ack
);

  // Table lookups, one per input
  epid_t             find_epid [NPORTS];
  logic [NPORTS-1:0] find_hit;
  port_t             find_port [NPORTS];

  // Router to ingress FIFO
  routed_beat_t      rt_beat [NPORTS];
  logic [NPORTS-1:0] rt_valid;
  logic [NPORTS-1:0] rt_ready;

  // Ingress FIFO outputs into the crosspoint
  routed_beat_t      ib_beat [NPORTS];
  logic [NPORTS-1:0] ib_valid;
  logic [NPORTS-1:0] ib_ready;

  // Crosspoint, first index is the output and second the input
  chdr_beat_t        xp_beat  [NPORTS][NPORTS];
  logic [NPORTS-1:0] xp_valid [NPORTS];
  logic [NPORTS-1:0] xp_ready [NPORTS];

  // Arbiter to egress FIFO
  chdr_beat_t        arb_beat [NPORTS];
  logic [NPORTS-1:0] arb_valid;
  logic [NPORTS-1:0] arb_ready;

  xb_route_table route_tbl_i (
    .clk         (clk),
    .reset       (reset),
    .i_cfg_stb   (i_cfg_stb),
    .i_cfg       (i_cfg),
    .o_cfg_ack   (o_cfg_ack),
    .i_find_epid (find_epid),
    .o_find_hit  (find_hit),
    .o_find_port (find_port)
  );

  // --------------------------------------------------------------------------
  // Ingress chains
  // --------------------------------------------------------------------------

  for (genvar n = 0; n < NPORTS; n++) begin : g_in
    xb_ingress_router router_i (
      .clk (clk), .reset (reset),
      .i_beat (i_in_beat[n]), .i_valid (i_in_valid[n]), .o_ready (o_in_ready[n]),
      .o_find_epid (find_epid[n]), .i_find_hit (find_hit[n]),
      .i_find_port (find_port[n]),
      .o_beat (rt_beat[n]), .o_valid (rt_valid[n]), .i_ready (rt_ready[n])
    );

    xb_stream_fifo #(.T_PAYLOAD(routed_beat_t), .DEPTH(IN_FIFO_DEPTH)) in_fifo_i (
      .clk (clk), .reset (reset),
      .i_data (rt_beat[n]), .i_valid (rt_valid[n]), .o_ready (rt_ready[n]),
      .o_data (ib_beat[n]), .o_valid (ib_valid[n]), .i_ready (ib_ready[n])
    );
  end

  // --------------------------------------------------------------------------
  // Crosspoint steering
  // --------------------------------------------------------------------------

  // Each FIFO head is offered only to the output named by its tag
  always_comb begin
    for (int o = 0; o < NPORTS; o++) begin
      for (int i = 0; i < NPORTS; i++) begin
        xp_beat[o][i]  = ib_beat[i].beat;
        xp_valid[o][i] = ib_valid[i] && (ib_beat[i].dest == port_t'(o));
      end
    end
  end

  // At most one arbiter grants a given input, so the OR is a plain merge
  always_comb begin
    for (int i = 0; i < NPORTS; i++) begin
      ib_ready[i] = 1'b0;
      for (int o = 0; o < NPORTS; o++) begin
        ib_ready[i] = ib_ready[i] | xp_ready[o][i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Egress chains
  // --------------------------------------------------------------------------

  for (genvar n = 0; n < NPORTS; n++) begin : g_out
    xb_egress_arbiter arb_i (
      .clk (clk), .reset (reset),
      .i_beats (xp_beat[n]), .i_valids (xp_valid[n]), .o_readies (xp_ready[n]),
      .o_beat (arb_beat[n]), .o_valid (arb_valid[n]), .i_ready (arb_ready[n])
    );

    xb_stream_fifo #(.T_PAYLOAD(chdr_beat_t), .DEPTH(OUT_FIFO_DEPTH)) out_fifo_i (
      .clk (clk), .reset (reset),
      .i_data (arb_beat[n]), .i_valid (arb_valid[n]), .o_ready (arb_ready[n]),
      .o_data (o_out_beat[n]), .o_valid (o_out_valid[n]), .i_ready (i_out_ready[n])
    );
  end

endmodule

//--- hw/xb_egress_arbiter.sv
`timescale 1ns/10ps

module xb_egress_arbiter import chdr_pkg::*, xbar_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  // Requests from all ingress FIFOs steered to this output
  input  chdr_beat_t        i_beats [NPORTS],
  input  logic [NPORTS-1:0] i_valids,
  output logic [NPORTS-1:0] o_readies,
  // Merged stream towards the egress FIFO
  output chdr_beat_t        o_beat,
  output logic              o_valid,
  input  logic              i_ready
);

  // Set from the first offered beat of a packet until its last beat moves
  logic  locked;

  // Input that owns the output while locked
  port_t grant_q;

  // Most recently completed grant, the round-robin search starts after it
  port_t last_grant;

  // Round-robin choice among the inputs that are requesting right now
  port_t rr_pick;
  logic  any_req;

  // Input currently connected to the output
  port_t sel;
  logic  active;
  logic  out_fire;

  // --------------------------------------------------------------------------
  // Round-robin selection
  // --------------------------------------------------------------------------

  // Walk the inputs from the far end back towards last_grant+1, so the
  // nearest requester in cyclic order is the one that sticks
  always_comb begin
    int idx;
    rr_pick = last_grant;
    any_req = |i_valids;
    for (int k = NPORTS; k >= 1; k--) begin
      idx = (int'(last_grant) + k) % NPORTS;
      if (i_valids[idx]) begin
        rr_pick = port_t'(idx);
      end
    end
  end

  // A held grant always wins over a new pick
  assign sel    = locked ? grant_q : rr_pick;
  assign active = locked || any_req;

  // --------------------------------------------------------------------------
  // Multiplexer
  // --------------------------------------------------------------------------

  assign o_beat   = i_beats[sel];
  assign o_valid  = i_valids[sel];
  assign out_fire = o_valid && i_ready;

  // Only the selected input sees the downstream ready
  always_comb begin
    for (int k = 0; k < NPORTS; k++) begin
      o_readies[k] = active && i_ready && (sel == port_t'(k));
    end
  end

  // --------------------------------------------------------------------------
  // Grant state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      locked     <= 1'b0;
      grant_q    <= '0;
      // Input 0 comes first after reset
      last_grant <= port_t'(NPORTS - 1);
    end else begin
      if (out_fire && o_beat.last) begin
        // Packet done, free the output and move the pointer
        locked     <= 1'b0;
        last_grant <= sel;
      end else if (o_valid && !locked) begin
        // Lock as soon as a head is offered so the output stays stable
        // even when the FIFO below is not ready yet
        locked  <= 1'b1;
        grant_q <= rr_pick;
      end
    end
  end

endmodule

//--- hw/xb_stream_fifo.sv
`timescale 1ns/10ps

module xb_stream_fifo import xbar_pkg::*; #(
  parameter type         T_PAYLOAD = routed_beat_t,
  parameter int unsigned DEPTH     = IN_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset,
  // Write side
  input  T_PAYLOAD i_data,
  input  logic     i_valid,
  output logic     o_ready,
  // Read side
  output T_PAYLOAD o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  // DEPTH is a power of two, so the pointers wrap without compare logic
  localparam int unsigned ADDR_W = $clog2(DEPTH);

  T_PAYLOAD          mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;

  // One extra bit so that full and empty are told apart
  logic [ADDR_W:0]   count;

  logic              wr_en;
  logic              rd_en;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  assign o_ready = (count != (ADDR_W+1)'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign wr_en = i_valid && o_ready;
  assign rd_en = o_valid && i_ready;

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage, the written entry shows at the output from the next cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

//--- hw/xb_ingress_router.sv
`timescale 1ns/10ps

module xb_ingress_router import chdr_pkg::*, xbar_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  // Input stream from the external port
  input  chdr_beat_t   i_beat,
  input  logic         i_valid,
  output logic         o_ready,
  // Lookup into the shared routing table
  output epid_t        o_find_epid,
  input  logic         i_find_hit,
  input  port_t        i_find_port,
  // Tagged stream towards the ingress FIFO
  output routed_beat_t o_beat,
  output logic         o_valid,
  input  logic         i_ready
);

  // Set while the beats between a header and its last beat are arriving
  logic         in_body;

  // Output port chosen at the header, held for the rest of the packet
  port_t        route_q;

  // Single output register stage
  routed_beat_t out_q;
  logic         out_valid_q;

  logic         in_fire;
  port_t        head_port;

  // --------------------------------------------------------------------------
  // Lookup and handshake
  // --------------------------------------------------------------------------

  // The ID field is presented on every beat, only the header uses the result
  assign o_find_epid = chdr_get_dst_epid(i_beat.data);

  // Unmapped endpoints fall back to the default port
  assign head_port = i_find_hit ? i_find_port : DEFAULT_PORT;

  // One-deep register, so accept when it is empty or draining this cycle
  assign o_ready = !out_valid_q || i_ready;
  assign in_fire = i_valid && o_ready;

  assign o_beat  = out_q;
  assign o_valid = out_valid_q;

  // --------------------------------------------------------------------------
  // Packet tracking
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      in_body     <= 1'b0;
      route_q     <= DEFAULT_PORT;
      out_valid_q <= 1'b0;
    end else begin
      if (in_fire) begin
        out_valid_q <= 1'b1;
        // A one-beat packet leaves us in the head state again
        in_body     <= !i_beat.last;
        if (!in_body) begin
          route_q <= head_port;
        end
      end else if (i_ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Payload register, the header takes the fresh lookup result and body
  // beats reuse the latched port
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_q.beat <= i_beat;
      out_q.dest <= in_body ? route_q : head_port;
    end
  end

endmodule

//--- hw/xb_route_table.sv
`timescale 1ns/10ps

module xb_route_table import chdr_pkg::*, xbar_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  // Config strobe port
  input  logic              i_cfg_stb,
  input  route_cfg_t        i_cfg,
  output logic              o_cfg_ack,
  // One lookup per ingress port
  input  epid_t             i_find_epid [NPORTS],
  output logic [NPORTS-1:0] o_find_hit,
  output port_t             o_find_port [NPORTS]
);

  // Entry storage, valid bits are the only state that needs clearing
  logic [TBL_SIZE-1:0] ent_valid;
  epid_t               ent_epid [TBL_SIZE];
  port_t               ent_port [TBL_SIZE];

  // Next entry to overwrite once the table has filled up
  logic [TBL_W-1:0]    wr_ptr;

  // Existing entry for the ID being written, if any
  logic                cfg_hit;
  logic [TBL_W-1:0]    cfg_idx;

  // --------------------------------------------------------------------------
  // Config write path
  // --------------------------------------------------------------------------

  always_comb begin
    cfg_hit = 1'b0;
    cfg_idx = '0;
    for (int e = 0; e < TBL_SIZE; e++) begin
      if (ent_valid[e] && (ent_epid[e] == i_cfg.epid)) begin
        cfg_hit = 1'b1;
        cfg_idx = TBL_W'(e);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ent_valid <= '0;
      wr_ptr    <= '0;
      o_cfg_ack <= 1'b0;
    end else begin
      // The ack is just the strobe delayed by one cycle
      o_cfg_ack <= i_cfg_stb;
      if (i_cfg_stb && !cfg_hit) begin
        ent_valid[wr_ptr] <= 1'b1;
        // Table size is a power of two so the pointer wraps by itself
        wr_ptr            <= wr_ptr + 1'b1;
      end
    end
  end

  // Keys and ports, a known ID is updated where it already lives
  always_ff @(posedge clk) begin
    if (i_cfg_stb) begin
      if (cfg_hit) begin
        ent_port[cfg_idx] <= i_cfg.port;
      end else begin
        ent_epid[wr_ptr] <= i_cfg.epid;
        ent_port[wr_ptr] <= i_cfg.port;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Lookup path
  // --------------------------------------------------------------------------

  // Every ingress port gets its own full compare against all entries
  always_comb begin
    for (int p = 0; p < NPORTS; p++) begin
      o_find_hit[p]  = 1'b0;
      o_find_port[p] = '0;
      for (int e = 0; e < TBL_SIZE; e++) begin
        if (ent_valid[e] && (ent_epid[e] == i_find_epid[p])) begin
          o_find_hit[p]  = 1'b1;
          o_find_port[p] = ent_port[e];
        end
      end
    end
  end

endmodule

//--- hw/xbar_pkg.sv
package xbar_pkg;

  import chdr_pkg::*;

  // --------------------------------------------------------------------------
  // Crossbar size and port indexing
  // --------------------------------------------------------------------------

  localparam int unsigned NPORTS = 4;
  localparam int unsigned PORT_W = 2;

  typedef logic [PORT_W-1:0] port_t;

  // Packets whose endpoint is not in the table leave on this port
  localparam port_t DEFAULT_PORT = 2'd0;

  // --------------------------------------------------------------------------
  // Routing table and buffering
  // --------------------------------------------------------------------------

  localparam int unsigned TBL_SIZE = 8;
  localparam int unsigned TBL_W    = 3;

  // Both FIFO depths must stay powers of two for pointer wrap
  localparam int unsigned IN_FIFO_DEPTH  = 4;
  localparam int unsigned OUT_FIFO_DEPTH = 2;

  // One mapping written through the config port
  typedef struct packed {
    epid_t epid;
    port_t port;
  } route_cfg_t;

  // A beat after ingress, carrying the output port it is steered to
  typedef struct packed {
    port_t      dest;
    chdr_beat_t beat;
  } routed_beat_t;

endpackage

//--- hw/chdr_pkg.sv
package chdr_pkg;

  // --------------------------------------------------------------------------
  // CHDR word layout
  // --------------------------------------------------------------------------

  // Width of one CHDR data word on the stream
  localparam int unsigned CHDR_W = 64;

  // Width of an endpoint ID as carried in the header
  localparam int unsigned EPID_W = 16;

  typedef logic [CHDR_W-1:0] chdr_word_t;
  typedef logic [EPID_W-1:0] epid_t;

  // One stream beat, the data word plus its end-of-packet flag
  typedef struct packed {
    logic       last;
    chdr_word_t data;
  } chdr_beat_t;

  // The destination endpoint sits in the lowest bits of the header word
  // and is only meaningful on the first beat of a packet
  function automatic epid_t chdr_get_dst_epid(input chdr_word_t header);
    return header[EPID_W-1:0];
  endfunction

endpackage
